// File: filelist.f
hw/fsb_cl_pkg.sv
hw/cl_reset_sync.sv
hw/ocl_slave.sv
hw/fsb_tx_assembler.sv
hw/fsb_loopback_node.sv
hw/fsb_rx_collector.sv
hw/cl_fsb_top.sv
tb/cl_fsb_asserts.sv
tb/tb_cl_fsb.sv

// File: hw/cl_fsb_top.sv
// top of the fsb loopback block; connects the host control bus to the reset, slave and fsb path
`timescale 1ns/1ps

module cl_fsb_top (
  input  logic                              clk,
  input  logic                              pipe_rst_n,
  input  logic                              flr_assert_i,
  output logic                              flr_done_o,
  input  logic                              ocl_wr_valid_i,
  input  fsb_cl_pkg::ocl_wr_t               ocl_wr_i,
  output logic                              ocl_wr_ready_o,
  output logic                              ocl_b_valid_o,
  output fsb_cl_pkg::axi_resp_e             ocl_b_resp_o,
  input  logic                              ocl_b_ready_i,
  input  logic                              ocl_ar_valid_i,
  input  logic [fsb_cl_pkg::OCL_ADDR_W-1:0] ocl_ar_addr_i,
  output logic                              ocl_ar_ready_o,
  output logic                              ocl_r_valid_o,
  output fsb_cl_pkg::ocl_rd_t               ocl_r_o,
  input  logic                              ocl_r_ready_i
);

  import fsb_cl_pkg::*;

  logic                          sync_rst_n;
  logic                          tx_req_valid;
  logic                          rx_req_valid;
  win_req_t                      win_req;
  logic                          tx_rsp_valid;
  win_rsp_t                      tx_rsp;
  logic                          rx_rsp_valid;
  win_rsp_t                      rx_rsp;
  logic [FSB_NODE_NUM-1:0]       node_v;
  logic [FSB_NODE_NUM-1:0]       node_ready;
  fsb_pkt_t                      node_pkt;
  logic [FSB_NODE_NUM-1:0]       ret_v;
  fsb_pkt_t [FSB_NODE_NUM-1:0]   ret_pkt;
  logic [FSB_NODE_NUM-1:0]       ret_yumi;

  // --------------------
  // reset and flr
  cl_reset_sync u_reset_sync (
    .clk         (clk),
    .pipe_rst_n  (pipe_rst_n),
    .flr_assert_i(flr_assert_i),
    .sync_rst_n_o(sync_rst_n),
    .flr_done_o  (flr_done_o)
  );

  // --------------------
  // control bus and window decode
  ocl_slave u_ocl_slave (
    .clk           (clk),
    .rst_n         (sync_rst_n),
    .wr_valid_i    (ocl_wr_valid_i),
    .wr_i          (ocl_wr_i),
    .wr_ready_o    (ocl_wr_ready_o),
    .b_valid_o     (ocl_b_valid_o),
    .b_resp_o      (ocl_b_resp_o),
    .b_ready_i     (ocl_b_ready_i),
    .ar_valid_i    (ocl_ar_valid_i),
    .ar_addr_i     (ocl_ar_addr_i),
    .ar_ready_o    (ocl_ar_ready_o),
    .r_valid_o     (ocl_r_valid_o),
    .r_o           (ocl_r_o),
    .r_ready_i     (ocl_r_ready_i),
    .tx_req_valid_o(tx_req_valid),
    .rx_req_valid_o(rx_req_valid),
    .req_o         (win_req),
    .tx_rsp_valid_i(tx_rsp_valid),
    .tx_rsp_i      (tx_rsp),
    .rx_rsp_valid_i(rx_rsp_valid),
    .rx_rsp_i      (rx_rsp)
  );

  // --------------------
  // fsb path
  fsb_tx_assembler u_tx (
    .clk         (clk),
    .rst_n       (sync_rst_n),
    .req_valid_i (tx_req_valid),
    .req_i       (win_req),
    .rsp_valid_o (tx_rsp_valid),
    .rsp_o       (tx_rsp),
    .node_v_o    (node_v),
    .node_pkt_o  (node_pkt),
    .node_ready_i(node_ready)
  );

  // all nodes see the same packet, node_v picks one
  for (genvar i = 0; i < FSB_NODE_NUM; i++)
  begin : g_node
    fsb_loopback_node u_node (
      .clk    (clk),
      .rst_n  (sync_rst_n),
      .v_i    (node_v[i]),
      .pkt_i  (node_pkt),
      .ready_o(node_ready[i]),
      .v_o    (ret_v[i]),
      .pkt_o  (ret_pkt[i]),
      .yumi_i (ret_yumi[i])
    );
  end

  fsb_rx_collector u_rx (
    .clk        (clk),
    .rst_n      (sync_rst_n),
    .ret_v_i    (ret_v),
    .ret_pkt_i  (ret_pkt),
    .ret_yumi_o (ret_yumi),
    .req_valid_i(rx_req_valid),
    .req_i      (win_req),
    .rsp_valid_o(rx_rsp_valid),
    .rsp_o      (rx_rsp)
  );

endmodule

// File: hw/cl_reset_sync.sv
// internal reset synchronizer and FLR done response; fed by the shell's reset pipe output
`timescale 1ns/1ps

module cl_reset_sync (
  input  logic clk,
  input  logic pipe_rst_n,
  input  logic flr_assert_i,
  output logic sync_rst_n_o,
  output logic flr_done_o
);

  logic pre_sync_rst_n;
  logic flr_assert_q;

  // internal reset lags pipe_rst_n by two edges
  always_ff @(posedge clk)
  begin
    if (!pipe_rst_n)
    begin
      pre_sync_rst_n <= 1'b0;
      sync_rst_n_o   <= 1'b0;
    end
    else
    begin
      pre_sync_rst_n <= 1'b1;
      sync_rst_n_o   <= pre_sync_rst_n;
    end
  end

  // done toggles while the request stays high
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n_o)
    begin
      flr_assert_q <= 1'b0;
      flr_done_o   <= 1'b0;
    end
    else
    begin
      flr_assert_q <= flr_assert_i;
      flr_done_o   <= flr_assert_q && !flr_done_o;
    end
  end

endmodule

// File: hw/fsb_cl_pkg.sv
// shared sizes, window map, response codes and bus/packet types; imported by every block
package fsb_cl_pkg;

  // control bus geometry
  localparam int OCL_DATA_W   = 32;
  localparam int OCL_ADDR_W   = 32;
  localparam int WIN_OFFSET_W = 12;

  // fsb side
  localparam int FSB_WIDTH     = 80;
  localparam int FSB_ID_W      = 4;
  localparam int FSB_NODE_NUM  = 4;
  localparam int NODE_SEL_W    = 2;
  localparam int RX_FIFO_DEPTH = 4;
  localparam int RX_PTR_W      = 2;
  localparam int RX_CNT_W      = 3;

  // word offsets inside a window
  localparam logic [WIN_OFFSET_W-1:0] OFF_W0 = 12'h000;
  localparam logic [WIN_OFFSET_W-1:0] OFF_W1 = 12'h004;
  localparam logic [WIN_OFFSET_W-1:0] OFF_W2 = 12'h008;
  localparam logic [WIN_OFFSET_W-1:0] OFF_W3 = 12'h00C;

  // id registers in the control window
  localparam logic [OCL_DATA_W-1:0] CL_ID0 = 32'hF000_1D0F;
  localparam logic [OCL_DATA_W-1:0] CL_ID1 = 32'h1D51_FEDC;

  // 4 KB windows, picked by address bits 13:12
  typedef enum logic [1:0] {
    WIN_CTRL     = 2'd0,
    WIN_FSB_TX   = 2'd1,
    WIN_FSB_RX   = 2'd2,
    WIN_UNMAPPED = 2'd3
  } ocl_win_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // write address and data share one channel
  typedef struct packed {
    logic [OCL_ADDR_W-1:0] addr;
    logic [OCL_DATA_W-1:0] data;
  } ocl_wr_t;

  typedef struct packed {
    logic [OCL_DATA_W-1:0] data;
    axi_resp_e             resp;
  } ocl_rd_t;

  // request from the bus slave into one fsb window
  typedef struct packed {
    logic                    wr;
    logic [WIN_OFFSET_W-1:0] offset;
    logic [OCL_DATA_W-1:0]   wdata;
  } win_req_t;

  typedef struct packed {
    logic [OCL_DATA_W-1:0] data;
    axi_resp_e             resp;
  } win_rsp_t;

  typedef struct packed {
    logic [FSB_ID_W-1:0]             dest_id;
    logic [FSB_ID_W-1:0]             src_id;
    logic [FSB_WIDTH-2*FSB_ID_W-1:0] payload;
  } fsb_pkt_t;

endpackage

// File: hw/fsb_loopback_node.sv
// one-entry fsb test node; echoes each packet back with source and destination swapped
`timescale 1ns/1ps

module fsb_loopback_node (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 v_i,
  input  fsb_cl_pkg::fsb_pkt_t pkt_i,
  output logic                 ready_o,
  output logic                 v_o,
  output fsb_cl_pkg::fsb_pkt_t pkt_o,
  input  logic                 yumi_i
);

  logic full_q;
  logic take;

  assign ready_o = !full_q;
  assign v_o     = full_q;
  assign take    = v_i && ready_o;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      full_q <= 1'b0;
    else if (take)
      full_q <= 1'b1;
    else if (yumi_i)
      full_q <= 1'b0;
  end

  // swap on capture so the reply is ready next cycle
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      pkt_o.dest_id <= pkt_i.src_id;
      pkt_o.src_id  <= pkt_i.dest_id;
      pkt_o.payload <= pkt_i.payload;
    end
  end

endmodule

// File: hw/fsb_rx_collector.sv
// fsb receive side; round-robin pulls node replies into a FIFO and serves the readback window
`timescale 1ns/1ps

module fsb_rx_collector (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  logic [fsb_cl_pkg::FSB_NODE_NUM-1:0]                     ret_v_i,
  input  fsb_cl_pkg::fsb_pkt_t [fsb_cl_pkg::FSB_NODE_NUM-1:0]     ret_pkt_i,
  output logic [fsb_cl_pkg::FSB_NODE_NUM-1:0]                     ret_yumi_o,
  input  logic                                                    req_valid_i,
  input  fsb_cl_pkg::win_req_t                                    req_i,
  output logic                                                    rsp_valid_o,
  output fsb_cl_pkg::win_rsp_t                                    rsp_o
);

  import fsb_cl_pkg::*;

  fsb_pkt_t              fifo_mem [RX_FIFO_DEPTH];
  logic [RX_PTR_W-1:0]   wr_ptr_q;
  logic [RX_PTR_W-1:0]   rd_ptr_q;
  logic [RX_CNT_W-1:0]   count_q;
  logic [NODE_SEL_W-1:0] last_q;
  logic [NODE_SEL_W-1:0] pick;
  logic                  pick_v;
  logic                  push;
  logic                  pop;
  logic                  empty;
  fsb_pkt_t              head;
  win_rsp_t              rsp_d;

  // search from the node after the last winner; the lowest step wins
  always_comb
  begin
    logic [NODE_SEL_W-1:0] idx;
    pick   = last_q;
    pick_v = 1'b0;
    for (int k = FSB_NODE_NUM; k > 0; k--)
    begin
      idx = NODE_SEL_W'(int'(last_q) + k);
      if (ret_v_i[idx])
      begin
        pick   = idx;
        pick_v = 1'b1;
      end
    end
  end

  assign push  = pick_v && (count_q != RX_FIFO_DEPTH);
  assign empty = (count_q == 0);
  assign head  = fifo_mem[rd_ptr_q];
  assign pop   = req_valid_i && !req_i.wr && (req_i.offset == OFF_W3) && !empty;

  always_comb
  begin
    for (int i = 0; i < FSB_NODE_NUM; i++)
      ret_yumi_o[i] = push && (pick == NODE_SEL_W'(i));
  end

  // readback words; packet words need a non-empty FIFO
  always_comb
  begin
    rsp_d.data = '0;
    rsp_d.resp = RESP_SLVERR;
    if (!req_i.wr)
    begin
      case (req_i.offset)
        OFF_W0: rsp_d = '{data: {{(OCL_DATA_W-RX_CNT_W){1'b0}}, count_q}, resp: RESP_OKAY};
        OFF_W1: if (!empty) rsp_d = '{data: head.payload[31:0], resp: RESP_OKAY};
        OFF_W2: if (!empty) rsp_d = '{data: head.payload[63:32], resp: RESP_OKAY};
        OFF_W3:
        begin
          if (!empty)
            rsp_d = '{data: {16'h0, head.dest_id, head.src_id, head.payload[71:64]},
                      resp: RESP_OKAY};
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      last_q      <= '0;
      rsp_valid_o <= 1'b0;
    end
    else
    begin
      rsp_valid_o <= req_valid_i;
      if (push)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        last_q   <= pick;
      end
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      fifo_mem[wr_ptr_q] <= ret_pkt_i[pick];
    if (req_valid_i)
      rsp_o <= rsp_d;
  end

endmodule

// File: hw/fsb_tx_assembler.sv
// fsb transmit window; builds an 80-bit packet from three writes and hands it to a node
`timescale 1ns/1ps

module fsb_tx_assembler (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                req_valid_i,
  input  fsb_cl_pkg::win_req_t                req_i,
  output logic                                rsp_valid_o,
  output fsb_cl_pkg::win_rsp_t                rsp_o,
  output logic [fsb_cl_pkg::FSB_NODE_NUM-1:0] node_v_o,
  output fsb_cl_pkg::fsb_pkt_t                node_pkt_o,
  input  logic [fsb_cl_pkg::FSB_NODE_NUM-1:0] node_ready_i
);

  import fsb_cl_pkg::*;

  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_e;

  tx_state_e             state_q;
  axi_resp_e             resp_q;
  logic [NODE_SEL_W-1:0] dest_sel;
  logic                  launch_ok;
  logic                  word_wr;
  logic                  node_fire;

  // launch word is {dest, src, payload[71:64]}
  assign launch_ok = req_i.wr && (req_i.offset == OFF_W2) && (req_i.wdata[15:12] < FSB_NODE_NUM);
  assign word_wr   = req_i.wr && (req_i.offset == OFF_W0 || req_i.offset == OFF_W1);
  assign dest_sel  = node_pkt_o.dest_id[NODE_SEL_W-1:0];
  assign node_fire = (state_q == TX_SEND) && node_ready_i[dest_sel];

  always_comb
  begin
    for (int i = 0; i < FSB_NODE_NUM; i++)
      node_v_o[i] = (state_q == TX_SEND) && (dest_sel == NODE_SEL_W'(i));
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q     <= TX_IDLE;
      rsp_valid_o <= 1'b0;
    end
    else
    begin
      rsp_valid_o <= 1'b0;
      if (state_q == TX_SEND)
      begin
        if (node_fire)
        begin
          state_q     <= TX_IDLE;
          rsp_valid_o <= 1'b1;
        end
      end
      else if (req_valid_i)
      begin
        // errors and word stores answer at once
        if (launch_ok)
          state_q <= TX_SEND;
        else
          rsp_valid_o <= 1'b1;
      end
    end
  end

  // packet words held until the next launch
  always_ff @(posedge clk)
  begin
    if (req_valid_i)
    begin
      resp_q <= (word_wr || launch_ok) ? RESP_OKAY : RESP_SLVERR;
      if (req_i.wr)
      begin
        case (req_i.offset)
          OFF_W0: node_pkt_o.payload[31:0] <= req_i.wdata;
          OFF_W1: node_pkt_o.payload[63:32] <= req_i.wdata;
          OFF_W2:
          begin
            node_pkt_o.payload[71:64] <= req_i.wdata[7:0];
            node_pkt_o.src_id         <= req_i.wdata[11:8];
            node_pkt_o.dest_id        <= req_i.wdata[15:12];
          end
          default: ;
        endcase
      end
    end
  end

  assign rsp_o = '{data: '0, resp: resp_q};

endmodule

// File: hw/ocl_slave.sv
// control bus slave; decodes the 4 KB windows, serves ctrl and unmapped, forwards fsb windows
`timescale 1ns/1ps

module ocl_slave (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wr_valid_i,
  input  fsb_cl_pkg::ocl_wr_t               wr_i,
  output logic                              wr_ready_o,
  output logic                              b_valid_o,
  output fsb_cl_pkg::axi_resp_e             b_resp_o,
  input  logic                              b_ready_i,
  input  logic                              ar_valid_i,
  input  logic [fsb_cl_pkg::OCL_ADDR_W-1:0] ar_addr_i,
  output logic                              ar_ready_o,
  output logic                              r_valid_o,
  output fsb_cl_pkg::ocl_rd_t               r_o,
  input  logic                              r_ready_i,
  output logic                              tx_req_valid_o,
  output logic                              rx_req_valid_o,
  output fsb_cl_pkg::win_req_t              req_o,
  input  logic                              tx_rsp_valid_i,
  input  fsb_cl_pkg::win_rsp_t              tx_rsp_i,
  input  logic                              rx_rsp_valid_i,
  input  fsb_cl_pkg::win_rsp_t              rx_rsp_i
);

  import fsb_cl_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LOCAL,
    WAIT_WIN,
    RESPOND
  } state_e;

  state_e                state_q;
  logic                  idle_rdy_q;
  ocl_win_e              win_q;
  logic [OCL_DATA_W-1:0] scratch_q;
  win_rsp_t              rsp_q;
  win_rsp_t              local_rsp;
  logic                  wr_fire;
  logic                  rd_fire;
  logic [OCL_ADDR_W-1:0] acc_addr;
  ocl_win_e              acc_win;

  // --------------------
  // accept side, write wins a tie
  assign wr_ready_o = idle_rdy_q;
  assign ar_ready_o = idle_rdy_q && !wr_valid_i;
  assign wr_fire    = wr_valid_i && wr_ready_o;
  assign rd_fire    = ar_valid_i && ar_ready_o;
  assign acc_addr   = wr_fire ? wr_i.addr : ar_addr_i;
  assign acc_win    = ocl_win_e'(acc_addr[WIN_OFFSET_W+1:WIN_OFFSET_W]);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q        <= IDLE;
      idle_rdy_q     <= 1'b0;
      tx_req_valid_o <= 1'b0;
      rx_req_valid_o <= 1'b0;
      scratch_q      <= '0;
    end
    else
    begin
      tx_req_valid_o <= 1'b0;
      rx_req_valid_o <= 1'b0;
      case (state_q)
        IDLE:
        begin
          if (wr_fire || rd_fire)
          begin
            idle_rdy_q     <= 1'b0;
            tx_req_valid_o <= (acc_win == WIN_FSB_TX);
            rx_req_valid_o <= (acc_win == WIN_FSB_RX);
            if (acc_win == WIN_FSB_TX || acc_win == WIN_FSB_RX)
              state_q <= WAIT_WIN;
            else
              state_q <= LOCAL;
          end
          else
          begin
            idle_rdy_q <= 1'b1;
          end
        end
        LOCAL:
        begin
          state_q <= RESPOND;
          if (req_o.wr && win_q == WIN_CTRL && req_o.offset == OFF_W2)
            scratch_q <= req_o.wdata;
        end
        WAIT_WIN:
        begin
          if (tx_rsp_valid_i || rx_rsp_valid_i)
            state_q <= RESPOND;
        end
        default:
        begin
          // held until the host takes it
          if (req_o.wr ? b_ready_i : r_ready_i)
          begin
            state_q    <= IDLE;
            idle_rdy_q <= 1'b1;
          end
        end
      endcase
    end
  end

  // --------------------
  // request and response payload
  always_ff @(posedge clk)
  begin
    if (wr_fire || rd_fire)
    begin
      win_q        <= acc_win;
      req_o.wr     <= wr_fire;
      req_o.offset <= acc_addr[WIN_OFFSET_W-1:0];
      req_o.wdata  <= wr_i.data;
    end
    if (state_q == LOCAL)
      rsp_q <= local_rsp;
    else if (tx_rsp_valid_i)
      rsp_q <= tx_rsp_i;
    else if (rx_rsp_valid_i)
      rsp_q <= rx_rsp_i;
  end

  // ctrl registers and unmapped space
  always_comb
  begin
    local_rsp.data = '0;
    local_rsp.resp = RESP_SLVERR;
    if (win_q == WIN_UNMAPPED)
      local_rsp.resp = RESP_DECERR;
    else if (req_o.wr)
    begin
      if (req_o.offset == OFF_W2)
        local_rsp.resp = RESP_OKAY;
    end
    else
    begin
      case (req_o.offset)
        OFF_W0: local_rsp = '{data: CL_ID0, resp: RESP_OKAY};
        OFF_W1: local_rsp = '{data: CL_ID1, resp: RESP_OKAY};
        OFF_W2: local_rsp = '{data: scratch_q, resp: RESP_OKAY};
        default: ;
      endcase
    end
  end

  assign b_valid_o = (state_q == RESPOND) && req_o.wr;
  assign b_resp_o  = rsp_q.resp;
  assign r_valid_o = (state_q == RESPOND) && !req_o.wr;
  assign r_o       = '{data: rsp_q.data, resp: rsp_q.resp};

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_cl_fsb -f filelist.f \
  && ./obj_dir/Vtb_cl_fsb > sim.log 2>&1 \
  || echo "sim failed" >> sim.log

cat sim.log
if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

// File: tb/cl_fsb_asserts.sv
// protocol assertions on the host bus and FLR; bound into cl_fsb_top for simulation
`timescale 1ns/1ps

module cl_fsb_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  flr_done_i,
  input logic                  wr_ready_i,
  input logic                  ar_ready_i,
  input logic                  b_valid_i,
  input logic                  b_ready_i,
  input fsb_cl_pkg::axi_resp_e b_resp_i,
  input logic                  r_valid_i,
  input logic                  r_ready_i,
  input fsb_cl_pkg::ocl_rd_t   r_i
);

  // responses stay put until the host takes them
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
    else $error("write response changed before b_ready");

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("read return changed before r_ready");

  // done is a toggle, never two high cycles
  flr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    flr_done_i |=> !flr_done_i)
    else $error("flr_done_o high for two cycles in a row");

  // all handshake outputs quiet right out of reset
  reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> !b_valid_i && !r_valid_i && !wr_ready_i && !ar_ready_i)
    else $error("handshake output high in the cycle after reset");

endmodule

bind cl_fsb_top cl_fsb_asserts u_asserts (
  .clk       (clk),
  .rst_n     (sync_rst_n),
  .flr_done_i(flr_done_o),
  .wr_ready_i(ocl_wr_ready_o),
  .ar_ready_i(ocl_ar_ready_o),
  .b_valid_i (ocl_b_valid_o),
  .b_ready_i (ocl_b_ready_i),
  .b_resp_i  (ocl_b_resp_o),
  .r_valid_i (ocl_r_valid_o),
  .r_ready_i (ocl_r_ready_i),
  .r_i       (ocl_r_o)
);

// File: tb/cl_fsb_patterns.hex
// columns: op addr wdata resp data; op 1 write, 2 read, 3 flr; resp 0 okay, 2 slverr, 3 decerr
// for flr, bit k of data is the expected flr_done_o after the k-th clock edge
// control window
2 00000000 00000000 0 F0001D0F
2 00000004 00000000 0 1D51FEDC
1 00000008 A5A55A5A 0 00000000
2 00000008 00000000 0 A5A55A5A
1 00000000 12345678 2 00000000
2 0000000C 00000000 2 00000000
// unmapped window
1 00003010 DEADBEEF 3 00000000
2 00003004 00000000 3 00000000
// empty receive FIFO
2 00002004 00000000 2 00000000
2 00002000 00000000 0 00000000
// one packet to each node, then a bad dest and a transmit read
1 00001000 11223344 0 00000000
1 00001004 55667788 0 00000000
1 00001008 000005A0 0 00000000
1 00001008 000016A1 0 00000000
1 00001008 000027A2 0 00000000
1 00001008 000038A3 0 00000000
1 00001008 000049A4 2 00000000
2 00001000 00000000 2 00000000
// readback with ids swapped
2 00002000 00000000 0 00000004
2 00002004 00000000 0 11223344
2 00002008 00000000 0 55667788
2 0000200C 00000000 0 000050A0
2 00002000 00000000 0 00000003
2 0000200C 00000000 0 000061A1
2 0000200C 00000000 0 000072A2
2 0000200C 00000000 0 000083A3
2 00002000 00000000 0 00000000
2 0000200C 00000000 2 00000000
1 00002000 00000001 2 00000000
// flr
3 00000000 00000000 0 00000014

// File: tb/tb_cl_fsb.sv
// testbench for cl_fsb_top; replays the bus and FLR pattern file and checks every response
`timescale 1ns/1ps

module tb_cl_fsb;

  import fsb_cl_pkg::*;

  localparam int PAT_MAX   = 64;
  localparam int PAT_WORDS = 5;

  typedef enum logic [3:0] {
    OP_END   = 4'h0,
    OP_WRITE = 4'h1,
    OP_READ  = 4'h2,
    OP_FLR   = 4'h3
  } op_e;

  // one line of the pattern file
  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] wdata;
    axi_resp_e   resp;
    logic [31:0] data;
  } pattern_t;

  logic                  clk;
  logic                  pipe_rst_n;
  logic                  flr_assert_i;
  logic                  flr_done_o;
  logic                  ocl_wr_valid_i;
  ocl_wr_t               ocl_wr_i;
  logic                  ocl_wr_ready_o;
  logic                  ocl_b_valid_o;
  axi_resp_e             ocl_b_resp_o;
  logic                  ocl_b_ready_i;
  logic                  ocl_ar_valid_i;
  logic [OCL_ADDR_W-1:0] ocl_ar_addr_i;
  logic                  ocl_ar_ready_o;
  logic                  ocl_r_valid_o;
  ocl_rd_t               ocl_r_o;
  logic                  ocl_r_ready_i;

  logic [31:0] pat_words [PAT_MAX*PAT_WORDS];
  int          num_pat;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  int          seed        = 70593;
  bit          reported    = 1'b0;
  bit          passed      = 1'b0;

  cl_fsb_top u_dut (
    .clk           (clk),
    .pipe_rst_n    (pipe_rst_n),
    .flr_assert_i  (flr_assert_i),
    .flr_done_o    (flr_done_o),
    .ocl_wr_valid_i(ocl_wr_valid_i),
    .ocl_wr_i      (ocl_wr_i),
    .ocl_wr_ready_o(ocl_wr_ready_o),
    .ocl_b_valid_o (ocl_b_valid_o),
    .ocl_b_resp_o  (ocl_b_resp_o),
    .ocl_b_ready_i (ocl_b_ready_i),
    .ocl_ar_valid_i(ocl_ar_valid_i),
    .ocl_ar_addr_i (ocl_ar_addr_i),
    .ocl_ar_ready_o(ocl_ar_ready_o),
    .ocl_r_valid_o (ocl_r_valid_o),
    .ocl_r_o       (ocl_r_o),
    .ocl_r_ready_i (ocl_r_ready_i)
  );

  always #5 clk = ~clk;

  // watchdog
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      stop_on_error($sformatf("DUT did not finish the patterns within %0d cycles", cycle_limit));
  end

  // --------------------
  task automatic stop_on_error(input string what);
    reported = 1'b1;
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val)
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp_val, act_val));
  endtask

  function automatic pattern_t fetch_pattern(input int idx);
    pattern_t p;
    p.op    = op_e'(pat_words[idx*PAT_WORDS][3:0]);
    p.addr  = pat_words[idx*PAT_WORDS+1];
    p.wdata = pat_words[idx*PAT_WORDS+2];
    p.resp  = axi_resp_e'(pat_words[idx*PAT_WORDS+3][1:0]);
    p.data  = pat_words[idx*PAT_WORDS+4];
    return p;
  endfunction

  // --------------------
  task automatic bus_access(input pattern_t pat, input string name);
    int gap;
    bit is_wr;
    is_wr = (pat.op == OP_WRITE);
    @(posedge clk);
    if (is_wr)
    begin
      ocl_wr_valid_i <= 1'b1;
      ocl_wr_i       <= '{addr: pat.addr, data: pat.wdata};
    end
    else
    begin
      ocl_ar_valid_i <= 1'b1;
      ocl_ar_addr_i  <= pat.addr;
    end
    // request stays up until the slave takes it
    @(negedge clk);
    while (is_wr ? !ocl_wr_ready_o : !ocl_ar_ready_o)
      @(negedge clk);
    @(posedge clk);
    ocl_wr_valid_i <= 1'b0;
    ocl_ar_valid_i <= 1'b0;
    // host stalls the response for 0 to 3 cycles
    gap = $random(seed) & 3;
    repeat (gap)
      @(posedge clk);
    ocl_b_ready_i <= is_wr;
    ocl_r_ready_i <= !is_wr;
    @(negedge clk);
    while (is_wr ? !ocl_b_valid_o : !ocl_r_valid_o)
      @(negedge clk);
    if (is_wr)
      check_value($sformatf("%s resp", name), 32'(pat.resp), 32'(ocl_b_resp_o));
    else
    begin
      check_value($sformatf("%s resp", name), 32'(pat.resp), 32'(ocl_r_o.resp));
      check_value($sformatf("%s data", name), pat.data, ocl_r_o.data);
    end
    @(posedge clk);
    ocl_b_ready_i <= 1'b0;
    ocl_r_ready_i <= 1'b0;
  endtask

  // data bit k is the expected done level after the k-th edge
  task automatic flr_request(input pattern_t pat, input string name);
    @(posedge clk);
    flr_assert_i <= 1'b1;
    for (int k = 0; k < 5; k++)
    begin
      @(negedge clk);
      check_value($sformatf("%s edge %0d", name, k), 32'(pat.data[k]), 32'(flr_done_o));
    end
    @(posedge clk);
    flr_assert_i <= 1'b0;
    repeat (3)
      @(posedge clk);
    @(negedge clk);
    check_value($sformatf("%s release", name), 32'd0, 32'(flr_done_o));
  endtask

  // --------------------
  initial
  begin
    string    name;
    pattern_t pat;
    clk            = 1'b0;
    pipe_rst_n     = 1'b0;
    flr_assert_i   = 1'b0;
    ocl_wr_valid_i = 1'b0;
    ocl_wr_i       = '0;
    ocl_b_ready_i  = 1'b0;
    ocl_ar_valid_i = 1'b0;
    ocl_ar_addr_i  = '0;
    ocl_r_ready_i  = 1'b0;
    for (int i = 0; i < PAT_MAX*PAT_WORDS; i++)
      pat_words[i] = '0;
    $readmemh("tb/cl_fsb_patterns.hex", pat_words);
    num_pat = 0;
    while (num_pat < PAT_MAX && pat_words[num_pat*PAT_WORDS] != 32'h0)
      num_pat++;
    if (num_pat == 0)
      stop_on_error("no patterns found in tb/cl_fsb_patterns.hex");
    cycle_limit = 64 * num_pat + 100;

    // reset low for three edges
    repeat (3)
      @(posedge clk);
    pipe_rst_n <= 1'b1;

    for (int i = 0; i < num_pat; i++)
    begin
      pat  = fetch_pattern(i);
      name = $sformatf("pattern %0d", i);
      case (pat.op)
        OP_WRITE, OP_READ: bus_access(pat, name);
        OP_FLR:            flr_request(pat, name);
        default:           stop_on_error($sformatf("%s has an unknown operation", name));
      endcase
    end

    repeat (2)
      @(posedge clk);
    passed = 1'b1;
    $display("sim passed");
    $finish;
  end

  // run ended early, e.g. on an assertion
  final
  begin
    if (!passed && !reported)
      $display("sim failed");
  end

endmodule
